// File: axi_pkg.sv
// AXI4 shared definitions
// Bus widths, burst and response encodings, and one packed payload
// struct per channel (AW, W, B, AR, R)

package axi_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // Transaction ID width
    localparam int AXI_ID_W   = 4;
    // Byte address width
    localparam int AXI_ADDR_W = 16;
    // Data bus width, every beat is full width
    localparam int AXI_DATA_W = 32;
    // One strobe per data byte
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Burst type, AXI4 AxBURST values
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Response code, AXI4 xRESP values
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    //////////////////////////////
    // Channel payloads
    //////////////////////////////

    // Write address
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        // Beats minus one
        logic [7:0]            len;
        axi_burst_e            burst;
    } axi_aw_t;

    // Write data
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    // Write response
    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    // Read address, same layout as AW
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        axi_burst_e            burst;
    } axi_ar_t;

    // Read data
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        axi_resp_e             resp;
        logic                  last;
    } axi_r_t;

endpackage

// File: axi_register_slice.sv
// Generic valid/ready register stage
// Registered output plus one skid entry, so both the forward path
// and the ready path are cut by flops. One cycle latency, full rate

`timescale 1ns/100ps

module axi_register_slice #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,

    // Upstream side
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,

    // Downstream side
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    // Skid entry, holds one item while the output is stalled
    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;

    // Output register free this cycle
    logic out_load;

    // Ready comes straight from a flop
    assign in_ready = ~skid_valid;

    // Empty or being consumed
    assign out_load = ~out_valid | out_ready;

    //////////////////////////////
    // Control state
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            // Accepted item with the output held goes to the skid entry
            if (in_valid && in_ready && out_valid && !out_ready) begin
                skid_valid <= 1'b1;
            end else if (out_ready) begin
                // Skid content moves to the output below
                skid_valid <= 1'b0;
            end

            if (out_load) begin
                out_valid <= in_valid | skid_valid;
            end
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        // Track the input while empty, frozen once it holds an item
        if (in_ready) begin
            skid_data <= in_data;
        end
        // Older skid item goes out first to keep order
        if (out_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
    end

endmodule

// File: axi_channel_slices.sv
// AXI4 five-channel register slice
// One register stage per channel: AW, W and AR forward toward the slave,
// B and R back toward the master. Each channel adds one cycle

`timescale 1ns/100ps

module axi_channel_slices (
    input  logic             clk,
    input  logic             rst_n,

    // Master side
    input  logic             s_aw_valid,
    input  axi_pkg::axi_aw_t s_aw,
    output logic             s_aw_ready,
    input  logic             s_w_valid,
    input  axi_pkg::axi_w_t  s_w,
    output logic             s_w_ready,
    output logic             s_b_valid,
    output axi_pkg::axi_b_t  s_b,
    input  logic             s_b_ready,
    input  logic             s_ar_valid,
    input  axi_pkg::axi_ar_t s_ar,
    output logic             s_ar_ready,
    output logic             s_r_valid,
    output axi_pkg::axi_r_t  s_r,
    input  logic             s_r_ready,

    // Slave side
    output logic             m_aw_valid,
    output axi_pkg::axi_aw_t m_aw,
    input  logic             m_aw_ready,
    output logic             m_w_valid,
    output axi_pkg::axi_w_t  m_w,
    input  logic             m_w_ready,
    input  logic             m_b_valid,
    input  axi_pkg::axi_b_t  m_b,
    output logic             m_b_ready,
    output logic             m_ar_valid,
    output axi_pkg::axi_ar_t m_ar,
    input  logic             m_ar_ready,
    input  logic             m_r_valid,
    input  axi_pkg::axi_r_t  m_r,
    output logic             m_r_ready
);

    //////////////////////////////
    // Master to slave
    //////////////////////////////

    axi_register_slice #(.WIDTH($bits(axi_pkg::axi_aw_t))) aw_slice_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_aw_valid), .in_data(s_aw), .in_ready(s_aw_ready),
        .out_valid(m_aw_valid), .out_data(m_aw), .out_ready(m_aw_ready)
    );

    axi_register_slice #(.WIDTH($bits(axi_pkg::axi_w_t))) w_slice_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_w_valid), .in_data(s_w), .in_ready(s_w_ready),
        .out_valid(m_w_valid), .out_data(m_w), .out_ready(m_w_ready)
    );

    axi_register_slice #(.WIDTH($bits(axi_pkg::axi_ar_t))) ar_slice_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_ar_valid), .in_data(s_ar), .in_ready(s_ar_ready),
        .out_valid(m_ar_valid), .out_data(m_ar), .out_ready(m_ar_ready)
    );

    //////////////////////////////
    // Slave to master
    //////////////////////////////

    // Input side faces the slave here
    axi_register_slice #(.WIDTH($bits(axi_pkg::axi_b_t))) b_slice_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(m_b_valid), .in_data(m_b), .in_ready(m_b_ready),
        .out_valid(s_b_valid), .out_data(s_b), .out_ready(s_b_ready)
    );

    axi_register_slice #(.WIDTH($bits(axi_pkg::axi_r_t))) r_slice_i (
        .clk(clk), .rst_n(rst_n),
        .in_valid(m_r_valid), .in_data(m_r), .in_ready(m_r_ready),
        .out_valid(s_r_valid), .out_data(s_r), .out_ready(s_r_ready)
    );

endmodule

// File: axi_sram_slave.sv
// AXI4 SRAM slave
// Word memory with independent write and read burst machines.
// INCR and FIXED bursts up to 16 beats, byte strobes on writes,
// SLVERR for WRAP bursts and for beats past the end of memory

`timescale 1ns/100ps

module axi_sram_slave #(
    parameter int MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             aw_valid,
    input  axi_pkg::axi_aw_t aw,
    output logic             aw_ready,
    input  logic             w_valid,
    input  axi_pkg::axi_w_t  w,
    output logic             w_ready,
    output logic             b_valid,
    output axi_pkg::axi_b_t  b,
    input  logic             b_ready,
    input  logic             ar_valid,
    input  axi_pkg::axi_ar_t ar,
    output logic             ar_ready,
    output logic             r_valid,
    output axi_pkg::axi_r_t  r,
    input  logic             r_ready
);

    // Word address with one spare bit so INCR never wraps back in range
    localparam int WORD_W    = axi_pkg::AXI_ADDR_W - 1;
    localparam int MEM_IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

    logic [axi_pkg::AXI_DATA_W-1:0] mem [MEM_WORDS];

    //////////////////////////////
    // Write machine
    //////////////////////////////

    wr_state_e                    wr_state;
    logic [axi_pkg::AXI_ID_W-1:0] wr_id;
    logic [WORD_W-1:0]            wr_word;
    axi_pkg::axi_burst_e          wr_burst;
    // Sticky, any failed beat in the burst
    logic                         wr_err;
    logic                         wr_beat_err;
    logic [MEM_IDX_W-1:0]         wr_idx;

    assign aw_ready    = (wr_state == WR_IDLE);
    assign w_ready     = (wr_state == WR_DATA);
    assign b_valid     = (wr_state == WR_RESP);
    assign wr_beat_err = (wr_burst == axi_pkg::BURST_WRAP) || (wr_word >= WORD_W'(MEM_WORDS));
    assign wr_idx      = wr_word[MEM_IDX_W-1:0];

    always_comb begin
        b.id   = wr_id;
        b.resp = wr_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            wr_err   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_valid) begin
                        wr_err   <= 1'b0;
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_valid) begin
                        wr_err <= wr_err | wr_beat_err;
                        // Burst length is taken from the last flag
                        if (w.last) begin
                            wr_state <= WR_RESP;
                        end
                    end
                end
                default: begin
                    if (b_ready) begin
                        wr_state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    // Request fields and address stepping
    always_ff @(posedge clk) begin
        if (wr_state == WR_IDLE && aw_valid) begin
            wr_id    <= aw.id;
            wr_word  <= {1'b0, aw.addr[axi_pkg::AXI_ADDR_W-1:2]};
            wr_burst <= aw.burst;
        end else if (wr_state == WR_DATA && w_valid && wr_burst == axi_pkg::BURST_INCR) begin
            wr_word <= wr_word + 1'b1;
        end
    end

    // Byte-strobed memory write, failed beats leave memory alone
    always_ff @(posedge clk) begin
        if (wr_state == WR_DATA && w_valid && !wr_beat_err) begin
            for (int i = 0; i < axi_pkg::AXI_STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Read machine
    //////////////////////////////

    rd_state_e                      rd_state;
    logic [7:0]                     rd_left;
    logic [axi_pkg::AXI_ID_W-1:0]   rd_id;
    logic [WORD_W-1:0]              rd_word;
    axi_pkg::axi_burst_e            rd_burst;
    logic [axi_pkg::AXI_DATA_W-1:0] rd_data;
    axi_pkg::axi_resp_e             rd_resp;
    // Next beat address, fetched one beat ahead
    logic [WORD_W-1:0]              rd_word_nxt;
    axi_pkg::axi_burst_e            rd_burst_nxt;
    logic                           rd_load;
    logic                           rd_beat_err;

    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_DATA);

    always_comb begin
        r.id   = rd_id;
        r.data = rd_data;
        r.resp = rd_resp;
        r.last = (rd_left == 8'd0);
    end

    // Load the data register on AR accept or on each consumed beat
    always_comb begin
        if (rd_state == RD_IDLE) begin
            rd_load      = ar_valid;
            rd_word_nxt  = {1'b0, ar.addr[axi_pkg::AXI_ADDR_W-1:2]};
            rd_burst_nxt = ar.burst;
        end else begin
            rd_load      = r_ready;
            rd_word_nxt  = (rd_burst == axi_pkg::BURST_INCR) ? rd_word + 1'b1 : rd_word;
            rd_burst_nxt = rd_burst;
        end
        rd_beat_err = (rd_burst_nxt == axi_pkg::BURST_WRAP)
                    || (rd_word_nxt >= WORD_W'(MEM_WORDS));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
            rd_left  <= 8'd0;
        end else if (rd_state == RD_IDLE) begin
            if (ar_valid) begin
                rd_left  <= ar.len;
                rd_state <= RD_DATA;
            end
        end else if (r_ready) begin
            // Stall holds everything while r_ready is low
            if (rd_left == 8'd0) begin
                rd_state <= RD_IDLE;
            end else begin
                rd_left <= rd_left - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == RD_IDLE && ar_valid) begin
            rd_id <= ar.id;
        end
        if (rd_load) begin
            rd_word  <= rd_word_nxt;
            rd_burst <= rd_burst_nxt;
            // Failed beats return zero
            if (rd_beat_err) begin
                rd_data <= '0;
                rd_resp <= axi_pkg::RESP_SLVERR;
            end else begin
                rd_data <= mem[rd_word_nxt[MEM_IDX_W-1:0]];
                rd_resp <= axi_pkg::RESP_OKAY;
            end
        end
    end

endmodule

// File: axi_slice_top.sv
// AXI4 register slice subsystem top
// Master port enters the five-channel slice, which drives the SRAM slave

`timescale 1ns/100ps

module axi_slice_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             aw_valid,
    input  axi_pkg::axi_aw_t aw,
    output logic             aw_ready,
    input  logic             w_valid,
    input  axi_pkg::axi_w_t  w,
    output logic             w_ready,
    output logic             b_valid,
    output axi_pkg::axi_b_t  b,
    input  logic             b_ready,
    input  logic             ar_valid,
    input  axi_pkg::axi_ar_t ar,
    output logic             ar_ready,
    output logic             r_valid,
    output axi_pkg::axi_r_t  r,
    input  logic             r_ready
);

    // Slice to SRAM channels
    logic mem_aw_valid, mem_aw_ready;
    logic mem_w_valid, mem_w_ready;
    logic mem_b_valid, mem_b_ready;
    logic mem_ar_valid, mem_ar_ready;
    logic mem_r_valid, mem_r_ready;
    axi_pkg::axi_aw_t mem_aw;
    axi_pkg::axi_w_t  mem_w;
    axi_pkg::axi_b_t  mem_b;
    axi_pkg::axi_ar_t mem_ar;
    axi_pkg::axi_r_t  mem_r;

    axi_channel_slices axi_channel_slices_i (
        .clk(clk), .rst_n(rst_n),
        .s_aw_valid(aw_valid), .s_aw(aw), .s_aw_ready(aw_ready),
        .s_w_valid(w_valid), .s_w(w), .s_w_ready(w_ready),
        .s_b_valid(b_valid), .s_b(b), .s_b_ready(b_ready),
        .s_ar_valid(ar_valid), .s_ar(ar), .s_ar_ready(ar_ready),
        .s_r_valid(r_valid), .s_r(r), .s_r_ready(r_ready),
        .m_aw_valid(mem_aw_valid), .m_aw(mem_aw), .m_aw_ready(mem_aw_ready),
        .m_w_valid(mem_w_valid), .m_w(mem_w), .m_w_ready(mem_w_ready),
        .m_b_valid(mem_b_valid), .m_b(mem_b), .m_b_ready(mem_b_ready),
        .m_ar_valid(mem_ar_valid), .m_ar(mem_ar), .m_ar_ready(mem_ar_ready),
        .m_r_valid(mem_r_valid), .m_r(mem_r), .m_r_ready(mem_r_ready)
    );

    axi_sram_slave #(.MEM_WORDS(MEM_WORDS)) axi_sram_slave_i (
        .clk(clk), .rst_n(rst_n),
        .aw_valid(mem_aw_valid), .aw(mem_aw), .aw_ready(mem_aw_ready),
        .w_valid(mem_w_valid), .w(mem_w), .w_ready(mem_w_ready),
        .b_valid(mem_b_valid), .b(mem_b), .b_ready(mem_b_ready),
        .ar_valid(mem_ar_valid), .ar(mem_ar), .ar_ready(mem_ar_ready),
        .r_valid(mem_r_valid), .r(mem_r), .r_ready(mem_r_ready)
    );

endmodule

// File: tb_axi_slice_top.sv
// Testbench for the AXI4 register slice subsystem
// Random writes and reads with random back-pressure, checked
// against a word-level memory model of the SRAM slave

`timescale 1ns/100ps

module tb_axi_slice_top;

    localparam int MEM_WORDS  = 1024;
    localparam int NUM_TXNS   = 200;
    // 200 bursts of up to 16 beats, about half the cycles stalled, with margin
    localparam int MAX_CYCLES = 40000;

    logic             clk;
    logic             rst_n;
    logic             aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic             ar_valid, ar_ready, r_valid, r_ready;
    axi_pkg::axi_aw_t aw;
    axi_pkg::axi_w_t  w;
    axi_pkg::axi_b_t  b;
    axi_pkg::axi_ar_t ar;
    axi_pkg::axi_r_t  r;

    // Expected SRAM contents
    logic [31:0] model_mem [MEM_WORDS];
    integer      seed;
    int          errors;
    int          checks;
    int          cycles;
    // A transaction owns the response channel
    logic        rd_busy;
    logic        wr_busy;
    // Response channels as seen one cycle earlier
    logic            b_held, r_held;
    axi_pkg::axi_b_t b_prev;
    axi_pkg::axi_r_t r_prev;

    axi_slice_top #(.MEM_WORDS(MEM_WORDS)) axi_slice_top_i (
        .clk(clk), .rst_n(rst_n),
        .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
        .w_valid(w_valid), .w(w), .w_ready(w_ready),
        .b_valid(b_valid), .b(b), .b_ready(b_ready),
        .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
        .r_valid(r_valid), .r(r), .r_ready(r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic finish_run;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles", cycles);
            errors++;
            finish_run();
        end
    end

    // Sampled at the falling edge, where all DUT outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            // Held response must keep valid and payload
            if (b_held && (!b_valid || b != b_prev)) begin
                $display("B channel dropped valid or changed payload while stalled");
                errors++;
            end
            if (r_held && (!r_valid || r != r_prev)) begin
                $display("R channel dropped valid or changed payload while stalled");
                errors++;
            end
            if (b_valid && !wr_busy) begin
                $display("B response with no write in progress");
                errors++;
            end
            if (r_valid && !rd_busy) begin
                $display("R beat with no read in progress");
                errors++;
            end
        end
        b_held = b_valid && !b_ready;
        r_held = r_valid && !r_ready;
        b_prev = b;
        r_prev = r;
    end

    //////////////////////////////
    // Transactions
    //////////////////////////////

    // Called just after a rising edge, returns just after one
    task automatic do_write(input logic [3:0] id, input logic [15:0] addr,
                            input logic [7:0] len, input axi_pkg::axi_burst_e burst,
                            input logic fill);
        axi_pkg::axi_aw_t req;
        axi_pkg::axi_w_t  beat_w;
        int               idx;
        int               n;
        logic             err;
        logic             any_err;
        logic             got;
        logic [15:0]      widx;
        wr_busy = 1'b1;
        any_err = 1'b0;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req.burst = burst;
        aw_valid <= 1'b1;
        aw       <= req;
        do begin
            @(negedge clk);
            got = aw_ready;
            @(posedge clk);
        end while (!got);
        aw_valid <= 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            // Occasional gap on W valid
            if (!fill && ($random(seed) & 3) == 0) begin
                w_valid <= 1'b0;
                n = 1 + ($unsigned($random(seed)) % 3);
                repeat (n) @(posedge clk);
            end
            idx = (addr >> 2) + ((burst == axi_pkg::BURST_INCR) ? beat : 0);
            err = (burst == axi_pkg::BURST_WRAP) || (idx >= MEM_WORDS);
            widx = idx[15:0];
            if (fill) begin
                beat_w.data = {widx ^ 16'h5a3c, widx};
                beat_w.strb = 4'hf;
            end else begin
                beat_w.data = $random(seed);
                beat_w.strb = $random(seed);
            end
            beat_w.last = (beat == len);
            w_valid <= 1'b1;
            w       <= beat_w;
            do begin
                @(negedge clk);
                got = w_ready;
                @(posedge clk);
            end while (!got);
            // Failed beats leave memory as it was
            if (err) begin
                any_err = 1'b1;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (beat_w.strb[i]) begin
                        model_mem[idx][8*i +: 8] = beat_w.data[8*i +: 8];
                    end
                end
            end
        end
        w_valid <= 1'b0;
        got = 1'b0;
        while (!got) begin
            b_ready <= $random(seed);
            @(negedge clk);
            if (b_valid && b_ready) begin
                got = 1'b1;
                checks++;
                if (b.id != id) begin
                    report_mismatch("b.id", b.id, id);
                end
                if (b.resp != (any_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY)) begin
                    report_mismatch("b.resp", b.resp,
                                    any_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY);
                end
            end
            @(posedge clk);
        end
        b_ready <= 1'b0;
        wr_busy = 1'b0;
    endtask

    task automatic do_read(input logic [3:0] id, input logic [15:0] addr,
                           input logic [7:0] len, input axi_pkg::axi_burst_e burst);
        axi_pkg::axi_ar_t req;
        int               idx;
        int               beat;
        logic             err;
        logic             got;
        logic [31:0]      exp_data;
        rd_busy = 1'b1;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req.burst = burst;
        ar_valid <= 1'b1;
        ar       <= req;
        do begin
            @(negedge clk);
            got = ar_ready;
            @(posedge clk);
        end while (!got);
        ar_valid <= 1'b0;
        beat = 0;
        while (beat <= len) begin
            r_ready <= $random(seed);
            @(negedge clk);
            if (r_valid && r_ready) begin
                idx = (addr >> 2) + ((burst == axi_pkg::BURST_INCR) ? beat : 0);
                err = (burst == axi_pkg::BURST_WRAP) || (idx >= MEM_WORDS);
                if (err) begin
                    exp_data = 32'h0;
                end else begin
                    exp_data = model_mem[idx];
                end
                checks++;
                if (r.data != exp_data) begin
                    report_mismatch("r.data", r.data, exp_data);
                end
                if (r.resp != (err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY)) begin
                    report_mismatch("r.resp", r.resp,
                                    err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY);
                end
                if (r.id != id) begin
                    report_mismatch("r.id", r.id, id);
                end
                if (r.last != (beat == len)) begin
                    report_mismatch("r.last", r.last, (beat == len));
                end
                beat++;
            end
            @(posedge clk);
        end
        r_ready <= 1'b0;
        rd_busy = 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int                  word;
        int                  sel;
        logic [15:0]         addr;
        logic [15:0]         last_wr_addr;
        logic [7:0]          len;
        axi_pkg::axi_burst_e burst;
        seed     = 37704;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        rd_busy  = 1'b0;
        wr_busy  = 1'b0;
        rst_n    = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        last_wr_addr = 16'h0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (b_valid || r_valid) begin
            $display("response valid high after reset");
            errors++;
        end
        if (!aw_ready || !ar_ready) begin
            $display("address ready low two cycles after reset");
            errors++;
        end
        @(posedge clk);
        // Give every word a known value first
        for (int k = 0; k < MEM_WORDS / 16; k++) begin
            do_write(4'h0, 16'(k * 64), 8'd15, axi_pkg::BURST_INCR, 1'b1);
        end
        for (int t = 0; t < NUM_TXNS; t++) begin
            sel = $unsigned($random(seed)) % 16;
            if (sel < 11) begin
                burst = axi_pkg::BURST_INCR;
            end else if (sel < 15) begin
                burst = axi_pkg::BURST_FIXED;
            end else begin
                burst = axi_pkg::BURST_WRAP;
            end
            len = $unsigned($random(seed)) % 16;
            // Mostly inside memory, a few past the end
            if ($unsigned($random(seed)) % 10 == 0) begin
                word = MEM_WORDS + $unsigned($random(seed)) % (16384 - MEM_WORDS);
            end else begin
                word = $unsigned($random(seed)) % MEM_WORDS;
            end
            addr = 16'(word * 4);
            if ($random(seed) & 1) begin
                do_write($random(seed), addr, len, burst, 1'b0);
                last_wr_addr = addr;
            end else begin
                // Half the reads go back over the last write
                if ($random(seed) & 1) begin
                    addr = last_wr_addr;
                end
                do_read($random(seed), addr, len, burst);
            end
        end
        finish_run();
    end

endmodule

// File: build.f
axi_pkg.sv
axi_register_slice.sv
axi_channel_slices.sv
axi_sram_slave.sv
axi_slice_top.sv
tb_axi_slice_top.sv

// File: Bender.yml
package:
  name: axi_slice_top

sources:
  - axi_pkg.sv
  - axi_register_slice.sv
  - axi_channel_slices.sv
  - axi_sram_slave.sv
  - axi_slice_top.sv
  - target: test
    files:
      - tb_axi_slice_top.sv
